// File: Makefile
VERILATOR = verilator
FLAGS = --timing --assert -Wno-fatal
TOP = cpuSystem_tb
FILELIST = cpuSystem.f
OBJDIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf $(OBJDIR)

// File: alu.sv
module alu (
	input logic [cpuSystemPkg::DataWidth-1:0] srcA,
	input logic [cpuSystemPkg::DataWidth-1:0] srcB,
	input cpuSystemPkg::aluOpT aluOp,
	output logic [cpuSystemPkg::DataWidth-1:0] result,
	output cpuSystemPkg::flagsT flags
);
	import cpuSystemPkg::*;

	always_comb begin
		unique case (aluOp)
			aluAdd: result = srcA + srcB;
			aluSub: result = srcA - srcB;
			aluAnd: result = srcA & srcB;
			aluOrr: result = srcA | srcB;
			default: result = '0;
		endcase
	end

	// Zero and sign of the result
	assign flags.z = (result == '0);
	assign flags.n = result[DataWidth-1];

endmodule

// File: cpu.sv
module cpu (
	input logic CLK,
	input logic rstN,
	input logic run,
	input logic [cpuSystemPkg::DataWidth-1:0] instr,
	input logic [cpuSystemPkg::DataWidth-1:0] readDataM,
	output logic [cpuSystemPkg::ProgAddrWidth-1:0] pcF,
	output logic memWriteM,
	output logic [cpuSystemPkg::DataWidth-1:0] aluOutM,
	output logic [cpuSystemPkg::DataWidth-1:0] writeDataM,
	output logic halted
);
	import cpuSystemPkg::*;

	logic [ProgAddrWidth-1:0] pcNext;
	logic [ProgAddrWidth-1:0] branchTargetE;

	logic [DataWidth-1:0] instrD;
	logic validD;
	opcodeT opcodeD;
	ctrlT decCtrlD;
	ctrlT ctrlD;
	logic [RegAddrWidth-1:0] ra1D;
	logic [RegAddrWidth-1:0] ra2D;
	logic [RegAddrWidth-1:0] wa3D;
	logic [DataWidth-1:0] rd1D;
	logic [DataWidth-1:0] rd2D;
	logic [DataWidth-1:0] immD;

	deRegT deReg;
	flagsT flags;
	flagsT aluFlagsE;
	logic condPassE;
	ctrlT ctrlE;
	logic branchTakenE;
	logic [DataWidth-1:0] srcAE;
	logic [DataWidth-1:0] srcBE;
	logic [DataWidth-1:0] writeDataE;
	logic [DataWidth-1:0] aluResultE;

	fwdSelT forwardA;
	fwdSelT forwardB;
	logic stallF;
	logic stallD;
	logic flushD;
	logic flushE;

	emRegT emReg;
	mwRegT mwReg;
	logic [DataWidth-1:0] resultW;

	// PC counts whole instructions
	assign pcNext = branchTakenE ? branchTargetE : pcF + 1'b1;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pcF <= '0;
		end else if (!run) begin
			pcF <= '0;
		end else if (!stallF) begin
			pcF <= pcNext;
		end
	end

	// Fetch/decode register where validD marks a real instruction
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			validD <= 1'b0;
		end else if (!run || flushD) begin
			validD <= 1'b0;
		end else if (!stallD) begin
			validD <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!stallD) begin
			instrD <= instr;
		end
	end

	assign opcodeD = opcodeT'(instrD[43:41]);

	decoder uDecoder (
		.opcode(opcodeD),
		.funct({instrD[40], instrD[35]}),
		.ctrlD(decCtrlD)
	);

	assign ctrlD = validD ? decCtrlD : ctrlT'('0);

	// STR reads its store data from Rd
	assign ra1D = instrD[34:30];
	assign ra2D = (opcodeD == opStr) ? instrD[29:25] : instrD[4:0];
	assign wa3D = instrD[29:25];
	assign immD = {{(DataWidth-24){instrD[23]}}, instrD[23:0]};

	regFile uRegFile (
		.CLK(CLK),
		.we3(mwReg.ctrl.regWrite),
		.ra1(ra1D),
		.ra2(ra2D),
		.wa3(mwReg.wa3),
		.wd3(resultW),
		.rd1(rd1D),
		.rd2(rd2D)
	);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			deReg <= '0;
		end else if (!run || flushE) begin
			deReg <= '0;
		end else begin
			deReg.ctrl <= ctrlD;
			deReg.cond <= condT'(instrD[47:44]);
			deReg.rd1 <= rd1D;
			deReg.rd2 <= rd2D;
			deReg.imm <= immD;
			deReg.ra1 <= ra1D;
			deReg.ra2 <= ra2D;
			deReg.wa3 <= wa3D;
			deReg.pc <= pcF - 1'b1;
		end
	end

	always_comb begin
		case (deReg.cond)
			condEq: condPassE = flags.z;
			condNe: condPassE = !flags.z;
			condAl: condPassE = 1'b1;
			default: condPassE = 1'b0;
		endcase
	end

	// Failed condition turns the instruction into a bubble
	always_comb begin
		ctrlE = deReg.ctrl;
		ctrlE.regWrite = deReg.ctrl.regWrite && condPassE;
		ctrlE.memWrite = deReg.ctrl.memWrite && condPassE;
		ctrlE.branch = deReg.ctrl.branch && condPassE;
		ctrlE.setFlags = deReg.ctrl.setFlags && condPassE;
	end

	assign branchTakenE = ctrlE.branch;
	assign branchTargetE = deReg.pc + deReg.imm[ProgAddrWidth-1:0];

	always_comb begin
		case (forwardA)
			fwdMem: srcAE = emReg.aluOut;
			fwdWb: srcAE = resultW;
			default: srcAE = deReg.rd1;
		endcase
		case (forwardB)
			fwdMem: writeDataE = emReg.aluOut;
			fwdWb: writeDataE = resultW;
			default: writeDataE = deReg.rd2;
		endcase
	end

	assign srcBE = deReg.ctrl.aluSrc ? deReg.imm : writeDataE;

	alu uAlu (
		.srcA(srcAE),
		.srcB(srcBE),
		.aluOp(deReg.ctrl.aluOp),
		.result(aluResultE),
		.flags(aluFlagsE)
	);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (ctrlE.setFlags) begin
			flags <= aluFlagsE;
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			emReg <= '0;
		end else if (!run) begin
			emReg <= '0;
		end else begin
			emReg.ctrl <= ctrlE;
			emReg.aluOut <= aluResultE;
			emReg.writeData <= writeDataE;
			emReg.wa3 <= deReg.wa3;
		end
	end

	assign memWriteM = emReg.ctrl.memWrite;
	assign aluOutM = emReg.aluOut;
	assign writeDataM = emReg.writeData;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			mwReg <= '0;
		end else if (!run) begin
			mwReg <= '0;
		end else begin
			mwReg.ctrl <= emReg.ctrl;
			mwReg.aluOut <= emReg.aluOut;
			mwReg.readData <= readDataM;
			mwReg.wa3 <= emReg.wa3;
		end
	end

	assign resultW = mwReg.ctrl.memToReg ? mwReg.readData : mwReg.aluOut;

	// Sticky until the next load phase
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			halted <= 1'b0;
		end else if (!run) begin
			halted <= 1'b0;
		end else if (mwReg.ctrl.halt) begin
			halted <= 1'b1;
		end
	end

	hazardUnit uHazardUnit (
		.ra1D(ra1D),
		.ra2D(ra2D),
		.ra1E(deReg.ra1),
		.ra2E(deReg.ra2),
		.wa3E(deReg.wa3),
		.wa3M(emReg.wa3),
		.wa3W(mwReg.wa3),
		.regWriteM(emReg.ctrl.regWrite),
		.regWriteW(mwReg.ctrl.regWrite),
		.memToRegE(deReg.ctrl.memToReg),
		.branchTakenE(branchTakenE),
		.haltD(ctrlD.halt),
		.forwardA(forwardA),
		.forwardB(forwardB),
		.stallF(stallF),
		.stallD(stallD),
		.flushD(flushD),
		.flushE(flushE)
	);

endmodule

// File: cpuSystem.f
cpuSystemPkg.sv
decoder.sv
regFile.sv
alu.sv
hazardUnit.sv
cpu.sv
progMem.sv
dataMem.sv
cpuSystem.sv
cpuSystem_sva.sv
cpuSystem_tb.sv

// File: cpuSystem.sv
module cpuSystem (
	input logic CLK,
	input logic rstN,
	input logic run,
	input logic progWe,
	input logic [cpuSystemPkg::ProgAddrWidth-1:0] progAddr,
	input logic [cpuSystemPkg::DataWidth-1:0] progData,
	output logic memWrite,
	output logic [cpuSystemPkg::DataWidth-1:0] memAddr,
	output logic [cpuSystemPkg::DataWidth-1:0] memWData,
	output logic halted
);
	import cpuSystemPkg::*;

	logic [ProgAddrWidth-1:0] pcF;
	logic [DataWidth-1:0] instr;
	logic [DataWidth-1:0] readData;

	cpu uCpu (
		.CLK(CLK),
		.rstN(rstN),
		.run(run),
		.instr(instr),
		.readDataM(readData),
		.pcF(pcF),
		.memWriteM(memWrite),
		.aluOutM(memAddr),
		.writeDataM(memWData),
		.halted(halted)
	);

	progMem uProgMem (
		.CLK(CLK),
		.we(progWe),
		.wAddr(progAddr),
		.wData(progData),
		.rAddr(pcF),
		.rData(instr)
	);

	// Only the low address bits reach the data memory
	dataMem uDataMem (
		.CLK(CLK),
		.we(memWrite),
		.addr(memAddr[DataAddrWidth-1:0]),
		.wData(memWData),
		.rData(readData)
	);

endmodule

// File: cpuSystemPkg.sv
package cpuSystemPkg;

	localparam int DataWidth = 48;
	localparam int RegAddrWidth = 5;
	localparam int ProgAddrWidth = 8;
	localparam int DataAddrWidth = 8;

	// Instruction word layout
	//   [47:44] cond    [43:41] opcode    [40] I (immediate operand)
	//   [35]    S (set flags)             [34:30] Rn    [29:25] Rd
	//   [23:0]  sign-extended imm24       [4:0] Rm
	// Bits 39:36 and 24 are reserved

	typedef enum logic [2:0] {
		opAdd  = 3'd0,
		opSub  = 3'd1,
		opAnd  = 3'd2,
		opOrr  = 3'd3,
		opLdr  = 3'd4,
		opStr  = 3'd5,
		opB    = 3'd6,
		opHalt = 3'd7
	} opcodeT;

	// Any other code never executes
	typedef enum logic [3:0] {
		condEq = 4'h0,
		condNe = 4'h1,
		condAl = 4'he
	} condT;

	// Same order as the ALU opcodes
	typedef enum logic [1:0] {
		aluAdd = 2'd0,
		aluSub = 2'd1,
		aluAnd = 2'd2,
		aluOrr = 2'd3
	} aluOpT;

	typedef enum logic [1:0] {
		fwdReg = 2'b00,
		fwdWb  = 2'b01,
		fwdMem = 2'b10
	} fwdSelT;

	typedef struct packed {
		logic z;
		logic n;
	} flagsT;

	typedef struct packed {
		logic regWrite;
		logic memWrite;
		logic memToReg;
		logic aluSrc;
		aluOpT aluOp;
		logic setFlags;
		logic branch;
		logic halt;
	} ctrlT;

	typedef struct packed {
		ctrlT ctrl;
		condT cond;
		logic [DataWidth-1:0] rd1;
		logic [DataWidth-1:0] rd2;
		logic [DataWidth-1:0] imm;
		logic [RegAddrWidth-1:0] ra1;
		logic [RegAddrWidth-1:0] ra2;
		logic [RegAddrWidth-1:0] wa3;
		logic [ProgAddrWidth-1:0] pc;
	} deRegT;

	typedef struct packed {
		ctrlT ctrl;
		logic [DataWidth-1:0] aluOut;
		logic [DataWidth-1:0] writeData;
		logic [RegAddrWidth-1:0] wa3;
	} emRegT;

	typedef struct packed {
		ctrlT ctrl;
		logic [DataWidth-1:0] aluOut;
		logic [DataWidth-1:0] readData;
		logic [RegAddrWidth-1:0] wa3;
	} mwRegT;

endpackage

// File: cpuSystem_sva.sv
module cpuChecks (
	input logic CLK,
	input logic rstN,
	input logic run,
	input logic halted,
	input logic memWriteM,
	input logic [cpuSystemPkg::ProgAddrWidth-1:0] pcF,
	input logic stallF,
	input logic stallD,
	input logic flushE,
	input logic memToRegE
);

	// Nothing reaches memory once the core has halted
	noStoreAfterHalt: assert property (@(posedge CLK) disable iff (!rstN)
		halted |-> !memWriteM)
		else $error("memory write while halted");

	// Stall with flush only happens for a load-use bubble
	stallFlushIsLoadUse: assert property (@(posedge CLK) disable iff (!rstN)
		(flushE && stallD) |-> memToRegE)
		else $error("decode stall and execute flush without a load in execute");

	pcHeldOnStall: assert property (@(posedge CLK) disable iff (!rstN)
		(stallF && run) |=> $stable(pcF))
		else $error("fetch PC moved during a stall");

endmodule

bind cpu cpuChecks cpuChecksI (
	.CLK(CLK),
	.rstN(rstN),
	.run(run),
	.halted(halted),
	.memWriteM(memWriteM),
	.pcF(pcF),
	.stallF(stallF),
	.stallD(stallD),
	.flushE(flushE),
	.memToRegE(deReg.ctrl.memToReg)
);

// File: cpuSystem_tb.sv
module cpuSystem_tb;
	import cpuSystemPkg::*;

	logic CLK;
	logic rstN;
	logic run;
	logic progWe;
	logic [ProgAddrWidth-1:0] progAddr;
	logic [DataWidth-1:0] progData;
	logic memWrite;
	logic [DataWidth-1:0] memAddr;
	logic [DataWidth-1:0] memWData;
	logic halted;

	logic [DataWidth-1:0] prog [$];
	logic [DataWidth-1:0] expAddr [$];
	logic [DataWidth-1:0] expData [$];
	string testName;
	int testErrors;
	int storeCount;
	int testsRun;
	int failedTests;

	cpuSystem dut_i (.*);

	always #2 CLK = ~CLK;

	// Appends one instruction whose low field holds imm24 or Rm
	function automatic void emit(condT c, opcodeT op, logic iBit, logic sBit,
			logic [4:0] rd, logic [4:0] rn, logic [23:0] low);
		prog.push_back({c, op, iBit, 4'b0000, sBit, rn, rd, 1'b0, low});
	endfunction

	// ISA model of the loaded program that fills the expected store queues
	function automatic bit interpret();
		logic [DataWidth-1:0] regsRef [32];
		logic [DataWidth-1:0] memRef [256];
		logic [DataWidth-1:0] w;
		logic [DataWidth-1:0] imm;
		logic [DataWidth-1:0] a;
		logic [DataWidth-1:0] b;
		logic [DataWidth-1:0] res;
		logic [7:0] pc;
		logic zRef;
		logic pass;
		opcodeT op;
		int step;
		pc = 8'd0;
		zRef = 1'b0;
		for (step = 0; step < 1000; step++) begin
			if (int'(pc) >= prog.size()) begin
				return 1'b0;
			end
			w = prog[pc];
			op = opcodeT'(w[43:41]);
			imm = {{24{w[23]}}, w[23:0]};
			a = regsRef[w[34:30]];
			b = w[40] ? imm : regsRef[w[4:0]];
			case (condT'(w[47:44]))
				condEq: pass = zRef;
				condNe: pass = !zRef;
				condAl: pass = 1'b1;
				default: pass = 1'b0;
			endcase
			// Loads and stores address with Rn plus offset
			case (op)
				opAdd: res = a + b;
				opSub: res = a - b;
				opAnd: res = a & b;
				opOrr: res = a | b;
				default: res = a + imm;
			endcase
			pc = pc + 8'd1;
			if (pass) begin
				case (op)
					opLdr: regsRef[w[29:25]] = memRef[res[7:0]];
					opStr: begin
						memRef[res[7:0]] = regsRef[w[29:25]];
						expAddr.push_back(res);
						expData.push_back(regsRef[w[29:25]]);
					end
					opB: pc = pc - 8'd1 + imm[7:0];
					opHalt: return 1'b1;
					default: begin
						regsRef[w[29:25]] = res;
						if (w[35]) begin
							zRef = (res == '0);
						end
					end
				endcase
			end
		end
		return 1'b0;
	endfunction

	// Store monitor against the expected sequence
	always @(negedge CLK) begin
		if (memWrite) begin
			storeCount++;
			if (halted) begin
				$display("%s: store issued while halted is high", testName);
				testErrors++;
			end
			if (expAddr.size() == 0) begin
				$display("%s: store to %0h when no store was expected", testName, memAddr);
				testErrors++;
			end else begin
				if (memAddr !== expAddr[0] || memWData !== expData[0]) begin
					$display("Error %s: expected [%0h] <= %0h, actual [%0h] <= %0h",
						testName, expAddr[0], expData[0], memAddr, memWData);
					testErrors++;
				end
				expAddr.delete(0);
				expData.delete(0);
			end
		end
	end

	task automatic runProgram(input string name);
		int i;
		int cycles;
		int expCount;
		bit expectHalt;
		testName = name;
		testErrors = 0;
		storeCount = 0;
		expAddr.delete();
		expData.delete();
		expectHalt = interpret();
		expCount = expAddr.size();
		run = 1'b0;
		for (i = 0; i < prog.size(); i++) begin
			progWe = 1'b1;
			progAddr = ProgAddrWidth'(i);
			progData = prog[i];
			@(posedge CLK);
			#1;
		end
		progWe = 1'b0;
		run = 1'b1;
		cycles = 0;
		while (!halted && cycles < 500) begin
			@(posedge CLK);
			#1;
			cycles++;
		end
		if (expectHalt && !halted) begin
			$display("%s: halted did not rise within 500 cycles", name);
			testErrors++;
		end
		// A few more cycles so a late store would still be seen
		repeat (8) @(posedge CLK);
		#1;
		if (halted !== expectHalt) begin
			$display("Error %s: halted expected %0b, actual %0b", name, expectHalt, halted);
			testErrors++;
		end
		if (storeCount != expCount) begin
			$display("Error %s: store count expected %0d, actual %0d",
				name, expCount, storeCount);
			testErrors++;
		end
		prog.delete();
		testsRun++;
		if (testErrors != 0) begin
			failedTests++;
		end
		$display("%s: %0d stores, %0d errors", name, storeCount, testErrors);
	endtask

	initial begin
		logic [23:0] base;
		logic [23:0] count;
		int r;
		void'($urandom(32'hbd37_60d6));
		CLK = 1'b0;
		rstN = 1'b0;
		run = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		testsRun = 0;
		failedTests = 0;
		testName = "reset";
		repeat (2) @(posedge CLK);
		#1;
		rstN = 1'b1;

		// Dependent ALU chain starting from a cleared r0
		base = 24'($urandom % 64);
		emit(condAl, opAnd, 1'b1, 1'b0, 5'd0, 5'd0, 24'd0);
		emit(condAl, opAdd, 1'b1, 1'b0, 5'd1, 5'd0, 24'($urandom));
		emit(condAl, opSub, 1'b1, 1'b0, 5'd2, 5'd1, 24'($urandom));
		emit(condAl, opAnd, 1'b0, 1'b0, 5'd3, 5'd2, 24'd1);
		emit(condAl, opOrr, 1'b1, 1'b0, 5'd4, 5'd3, 24'($urandom));
		// r4 rewritten so the next ADD finds it in both M and W
		emit(condAl, opAdd, 1'b0, 1'b0, 5'd4, 5'd4, 24'd3);
		emit(condAl, opAdd, 1'b0, 1'b0, 5'd5, 5'd4, 24'd2);
		for (r = 1; r <= 5; r++) begin
			emit(condAl, opStr, 1'b1, 1'b0, 5'(r), 5'd0, base + 24'(r));
		end
		emit(condAl, opHalt, 1'b0, 1'b0, 5'd0, 5'd0, 24'd0);
		runProgram("alu chain");

		// Load followed by an immediate use two times
		base = 24'($urandom % 64 + 100);
		emit(condAl, opAnd, 1'b1, 1'b0, 5'd0, 5'd0, 24'd0);
		emit(condAl, opAdd, 1'b1, 1'b0, 5'd6, 5'd0, 24'($urandom));
		emit(condAl, opStr, 1'b1, 1'b0, 5'd6, 5'd0, base);
		emit(condAl, opLdr, 1'b1, 1'b0, 5'd7, 5'd0, base);
		emit(condAl, opAdd, 1'b1, 1'b0, 5'd8, 5'd7, 24'($urandom));
		emit(condAl, opStr, 1'b1, 1'b0, 5'd8, 5'd0, base + 24'd1);
		emit(condAl, opLdr, 1'b1, 1'b0, 5'd9, 5'd0, base + 24'd1);
		emit(condAl, opStr, 1'b1, 1'b0, 5'd9, 5'd0, base + 24'd2);
		emit(condAl, opHalt, 1'b0, 1'b0, 5'd0, 5'd0, 24'd0);
		runProgram("load use");

		// Z set and then N set with Z clear
		base = 24'd10;
		emit(condAl, opAnd, 1'b1, 1'b0, 5'd0, 5'd0, 24'd0);
		emit(condAl, opAdd, 1'b1, 1'b0, 5'd1, 5'd0, 24'($urandom % 1000 + 1));
		emit(condAl, opSub, 1'b0, 1'b1, 5'd2, 5'd1, 24'd1);
		emit(condEq, opStr, 1'b1, 1'b0, 5'd1, 5'd0, base);
		emit(condNe, opStr, 1'b1, 1'b0, 5'd1, 5'd0, base + 24'd1);
		emit(condAl, opSub, 1'b0, 1'b1, 5'd3, 5'd0, 24'd1);
		emit(condEq, opStr, 1'b1, 1'b0, 5'd3, 5'd0, base + 24'd2);
		emit(condNe, opStr, 1'b1, 1'b0, 5'd3, 5'd0, base + 24'd3);
		emit(condAl, opHalt, 1'b0, 1'b0, 5'd0, 5'd0, 24'd0);
		runProgram("conditional");

		// Forward skip and not-taken EQ before a countdown loop
		count = 24'($urandom % 8 + 1);
		emit(condAl, opAnd, 1'b1, 1'b0, 5'd0, 5'd0, 24'd0);
		emit(condAl, opAdd, 1'b1, 1'b0, 5'd1, 5'd0, count);
		emit(condAl, opB, 1'b1, 1'b0, 5'd0, 5'd0, 24'd3);
		emit(condAl, opStr, 1'b1, 1'b0, 5'd1, 5'd0, 24'd20);
		emit(condAl, opStr, 1'b1, 1'b0, 5'd1, 5'd0, 24'd21);
		emit(condAl, opSub, 1'b1, 1'b1, 5'd9, 5'd1, 24'd0);
		emit(condEq, opB, 1'b1, 1'b0, 5'd0, 5'd0, 24'd2);
		emit(condAl, opStr, 1'b1, 1'b0, 5'd1, 5'd0, 24'd22);
		emit(condAl, opStr, 1'b1, 1'b0, 5'd1, 5'd0, 24'd30);
		emit(condAl, opSub, 1'b1, 1'b1, 5'd1, 5'd1, 24'd1);
		emit(condNe, opB, 1'b1, 1'b0, 5'd0, 5'd0, 24'hff_fffe);
		emit(condAl, opHalt, 1'b0, 1'b0, 5'd0, 5'd0, 24'd0);
		runProgram("branches");

		// First HALT is jumped over and the second one stops the core
		emit(condAl, opAnd, 1'b1, 1'b0, 5'd0, 5'd0, 24'd0);
		emit(condAl, opAdd, 1'b1, 1'b0, 5'd1, 5'd0, 24'($urandom));
		emit(condAl, opB, 1'b1, 1'b0, 5'd0, 5'd0, 24'd2);
		emit(condAl, opHalt, 1'b0, 1'b0, 5'd0, 5'd0, 24'd0);
		emit(condAl, opStr, 1'b1, 1'b0, 5'd1, 5'd0, 24'd40);
		emit(condAl, opHalt, 1'b0, 1'b0, 5'd0, 5'd0, 24'd0);
		emit(condAl, opStr, 1'b1, 1'b0, 5'd1, 5'd0, 24'd41);
		runProgram("halt");

		$display("Tests run: %0d, failed: %0d", testsRun, failedTests);
		if (failedTests == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: dataMem.sv
module dataMem (
	input logic CLK,
	input logic we,
	input logic [cpuSystemPkg::DataAddrWidth-1:0] addr,
	input logic [cpuSystemPkg::DataWidth-1:0] wData,
	output logic [cpuSystemPkg::DataWidth-1:0] rData
);
	import cpuSystemPkg::*;

	logic [DataWidth-1:0] mem [0:(1 << DataAddrWidth)-1];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= wData;
		end
	end

	// Combinational read for the memory stage
	assign rData = mem[addr];

endmodule

// File: decoder.sv
module decoder (
	input cpuSystemPkg::opcodeT opcode,
	input logic [1:0] funct,
	output cpuSystemPkg::ctrlT ctrlD
);
	import cpuSystemPkg::*;

	// funct carries the I bit on top and the S bit below
	logic iBit;
	logic sBit;

	assign iBit = funct[1];
	assign sBit = funct[0];

	always_comb begin
		ctrlD = '0;
		unique case (opcode)
			opAdd, opSub, opAnd, opOrr: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrc = iBit;
				ctrlD.setFlags = sBit;
				// Low opcode bits select the ALU operation directly
				ctrlD.aluOp = aluOpT'(opcode[1:0]);
			end
			opLdr: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.memToReg = 1'b1;
				ctrlD.aluSrc = 1'b1;
				ctrlD.aluOp = aluAdd;
			end
			opStr: begin
				ctrlD.memWrite = 1'b1;
				ctrlD.aluSrc = 1'b1;
				ctrlD.aluOp = aluAdd;
			end
			opB: begin
				ctrlD.branch = 1'b1;
			end
			opHalt: begin
				ctrlD.halt = 1'b1;
			end
			default: ctrlD = '0;
		endcase
	end

endmodule

// File: hazardUnit.sv
module hazardUnit (
	input logic [cpuSystemPkg::RegAddrWidth-1:0] ra1D,
	input logic [cpuSystemPkg::RegAddrWidth-1:0] ra2D,
	input logic [cpuSystemPkg::RegAddrWidth-1:0] ra1E,
	input logic [cpuSystemPkg::RegAddrWidth-1:0] ra2E,
	input logic [cpuSystemPkg::RegAddrWidth-1:0] wa3E,
	input logic [cpuSystemPkg::RegAddrWidth-1:0] wa3M,
	input logic [cpuSystemPkg::RegAddrWidth-1:0] wa3W,
	input logic regWriteM,
	input logic regWriteW,
	input logic memToRegE,
	input logic branchTakenE,
	input logic haltD,
	output cpuSystemPkg::fwdSelT forwardA,
	output cpuSystemPkg::fwdSelT forwardB,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE
);
	import cpuSystemPkg::*;

	logic ldrStall;
	logic haltStall;

	// Memory stage wins over writeback
	function automatic fwdSelT selectFwd(input logic [RegAddrWidth-1:0] ra);
		if (regWriteM && (wa3M == ra)) begin
			return fwdMem;
		end else if (regWriteW && (wa3W == ra)) begin
			return fwdWb;
		end
		return fwdReg;
	endfunction

	always_comb begin
		forwardA = selectFwd(ra1E);
		forwardB = selectFwd(ra2E);
	end

	// Load result is not ready until writeback
	assign ldrStall = memToRegE && ((wa3E == ra1D) || (wa3E == ra2D));

	// HALT parks in decode unless a taken branch discards it
	assign haltStall = haltD && !branchTakenE;

	assign stallF = ldrStall || haltStall;
	assign stallD = ldrStall || haltStall;
	assign flushD = branchTakenE;
	assign flushE = ldrStall || branchTakenE;

endmodule

// File: progMem.sv
module progMem (
	input logic CLK,
	input logic we,
	input logic [cpuSystemPkg::ProgAddrWidth-1:0] wAddr,
	input logic [cpuSystemPkg::DataWidth-1:0] wData,
	input logic [cpuSystemPkg::ProgAddrWidth-1:0] rAddr,
	output logic [cpuSystemPkg::DataWidth-1:0] rData
);
	import cpuSystemPkg::*;

	logic [DataWidth-1:0] mem [0:(1 << ProgAddrWidth)-1];

	// Loader port
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[wAddr] <= wData;
		end
	end

	// Fetch sees the word in the same cycle
	assign rData = mem[rAddr];

endmodule

// File: regFile.sv
module regFile (
	input logic CLK,
	input logic we3,
	input logic [cpuSystemPkg::RegAddrWidth-1:0] ra1,
	input logic [cpuSystemPkg::RegAddrWidth-1:0] ra2,
	input logic [cpuSystemPkg::RegAddrWidth-1:0] wa3,
	input logic [cpuSystemPkg::DataWidth-1:0] wd3,
	output logic [cpuSystemPkg::DataWidth-1:0] rd1,
	output logic [cpuSystemPkg::DataWidth-1:0] rd2
);
	import cpuSystemPkg::*;

	logic [DataWidth-1:0] regs [0:(1 << RegAddrWidth)-1];

	// Falling-edge write lets decode see the writeback value in the same cycle
	always_ff @(negedge CLK) begin
		if (we3) begin
			regs[wa3] <= wd3;
		end
	end

	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

endmodule
